// ==== Bender.yml ====
package:
  name: thread_unit

sources:
  # packages first, then the blocks and the top level
  - files:
      - design/cpu_core_pkg.sv
      - design/cpu_msg_pkg.sv
      - design/cmd_sequencer.sv
      - design/thread_ctlr.sv
      - design/thread_dispatcher.sv
      - design/thread_unit_top.sv

  # testbench, top module thread_unit_tb
  - target: simulation
    files:
      - sim/thread_unit_assertions.sv
      - sim/thread_unit_checker.sv
      - sim/thread_unit_tb.sv

// ==== all.f ====
design/cpu_core_pkg.sv
design/cpu_msg_pkg.sv
design/cmd_sequencer.sv
design/thread_ctlr.sv
design/thread_dispatcher.sv
design/thread_unit_top.sv
sim/thread_unit_assertions.sv
sim/thread_unit_checker.sv
sim/thread_unit_tb.sv

// ==== design/cmd_sequencer.sv ====
`timescale 1ns/100ps

module cmd_sequencer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                cmd_valid,
  input  logic [cpu_core_pkg::cmd_w-1:0]      command,
  input  logic [cpu_core_pkg::data_w-1:0]     src0,
  input  logic [cpu_core_pkg::data_w-1:0]     src1,
  input  logic                                next_state,
  output logic [cpu_core_pkg::state_w-1:0]    state,
  output logic [cpu_core_pkg::cmd_code_w-1:0] cmd_code,
  output logic [cpu_core_pkg::data_w-1:0]     op0,
  output logic [cpu_core_pkg::data_w-1:0]     op1,
  output logic                                busy,
  output logic                                done
);
  import cpu_core_pkg::*;

  // strobe taken only from idle
  logic accept;

  assign accept = cmd_valid && (state == st_idle);

  // pipeline state
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_alu_begin;
          end
        end
        // controller decides how long we stay here
        st_alu_begin: begin
          if (next_state) begin
            state <= st_alu_results;
          end
        end
        // single write-back cycle
        st_alu_results: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // command code and operands
  // held steady for the whole command
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_code <= command[cmd_code_lsb +: cmd_code_w];
      op0      <= src0;
      op1      <= src1;
    end
  end

  // busy covers alu_begin and the write-back cycle
  assign busy = (state != st_idle);

  // done lines up with dst valid
  assign done = (state == st_alu_results);

endmodule

// ==== design/cpu_core_pkg.sv ====
package cpu_core_pkg;

  // datapath widths
  localparam int data_w = 32;
  localparam int addr_w = 32;

  // command word
  localparam int cmd_w = 32;

  // 4-bit code sits at the top of the command word
  localparam int cmd_code_w   = 4;
  localparam int cmd_code_lsb = cmd_w - cmd_code_w;

  // thread commands
  localparam logic [cmd_code_w-1:0] cmd_fork = 4'd1;
  localparam logic [cmd_code_w-1:0] cmd_stop = 4'd2;

  // pipeline state register
  localparam int state_w = 2;

  // waiting for a command
  localparam logic [state_w-1:0] st_idle = 2'd0;

  // command held, controller working on it
  localparam logic [state_w-1:0] st_alu_begin = 2'd1;

  // write-back cycle, result on dst
  localparam logic [state_w-1:0] st_alu_results = 2'd2;

  // code 3 never reached
  // sequencer falls back to idle on it

endpackage

// ==== design/cpu_msg_pkg.sv ====
package cpu_msg_pkg;

  // inter-cpu message bus
  localparam int cpu_msg_w = 8;

  // bus idle value
  localparam logic [cpu_msg_w-1:0] msg_none = 8'h00;

  // requests from the thread controller
  localparam logic [cpu_msg_w-1:0] msg_fork_thrd = 8'h10;
  localparam logic [cpu_msg_w-1:0] msg_stop_thrd = 8'h20;

  // replies from the dispatcher
  localparam logic [cpu_msg_w-1:0] msg_fork_done = 8'h11;
  localparam logic [cpu_msg_w-1:0] msg_stop_done = 8'h21;

  // thread table
  localparam int num_threads = 8;
  localparam int thread_id_w = 3;

  // cycles from request pulse to reply
  localparam int reply_delay = 3;

  // full table on fork or no match on stop
  localparam logic [cpu_core_pkg::data_w-1:0] result_none = '1;

endpackage

// ==== design/thread_ctlr.sv ====
`timescale 1ns/100ps

module thread_ctlr (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                clk_oe,
  input  logic [cpu_core_pkg::state_w-1:0]    state,
  input  logic [cpu_core_pkg::cmd_code_w-1:0] cmd_code,
  input  logic [cpu_core_pkg::data_w-1:0]     src0,
  input  logic [cpu_core_pkg::data_w-1:0]     src1,
  input  logic [cpu_core_pkg::addr_w-1:0]     base_addr_data,
  input  logic                                disp_online,
  input  logic [cpu_msg_pkg::cpu_msg_w-1:0]   cpu_msg_in,
  input  logic [cpu_core_pkg::data_w-1:0]     data_in,
  output logic [cpu_msg_pkg::cpu_msg_w-1:0]   cpu_msg_out,
  output logic                                cpu_msg_pulse,
  output logic [cpu_core_pkg::addr_w-1:0]     addr_out,
  output logic [cpu_core_pkg::data_w-1:0]     data_out,
  output logic [cpu_core_pkg::data_w-1:0]     dst,
  output logic                                next_state
);
  import cpu_core_pkg::*;
  import cpu_msg_pkg::*;

  // decoded command
  logic                 is_thread_cmd;
  logic [cpu_msg_w-1:0] req_code;
  logic [cpu_msg_w-1:0] done_code;
  logic [addr_w-1:0]    req_addr;
  logic [data_w-1:0]    req_data;

  // request held for the pulse cycle
  logic [cpu_msg_w-1:0] msg_r;
  logic [addr_w-1:0]    addr_r;
  logic [data_w-1:0]    data_r;

  // request out, waiting for reply
  logic sent;
  // reply seen while clk_oe was low
  logic reply_held;
  // command finished, next_state waiting for clk_oe
  logic fin_r;

  logic act;
  logic reply_hit;
  logic send_req;
  logic finish;

  always_comb begin
    is_thread_cmd = (cmd_code == cmd_fork) || (cmd_code == cmd_stop);
    req_code      = (cmd_code == cmd_fork) ? msg_fork_thrd : msg_stop_thrd;
    done_code     = (cmd_code == cmd_fork) ? msg_fork_done : msg_stop_done;
    req_addr      = src0 + base_addr_data;
    // argument falls back to src0 when src1 is zero
    req_data      = (src1 != '0) ? src1 + base_addr_data : src0 + base_addr_data;
  end

  // work only in alu_begin, and not again once the finish is pending
  assign act = clk_oe && (state == st_alu_begin) && !fin_r;

  // reply is a single cycle wide
  // caught even with clk_oe low
  assign reply_hit = sent && (cpu_msg_in == done_code);

  // one request per command, only with the dispatcher up
  assign send_req = act && is_thread_cmd && !sent && disp_online;

  // other codes finish at once
  assign finish = act && (!is_thread_cmd || reply_hit || reply_held);

  // held back while halted
  assign next_state = fin_r && clk_oe;

  // handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      cpu_msg_pulse <= 1'b0;
      fin_r         <= 1'b0;
      sent          <= 1'b0;
      reply_held    <= 1'b0;
    end else begin
      // request strobe drops after one cycle even when halted
      cpu_msg_pulse <= send_req;
      if (finish) begin
        fin_r <= 1'b1;
      end else if (clk_oe) begin
        fin_r <= 1'b0;
      end
      if (send_req) begin
        sent <= 1'b1;
      end else if (finish) begin
        sent <= 1'b0;
      end
      if (finish) begin
        reply_held <= 1'b0;
      end else if (reply_hit) begin
        reply_held <= 1'b1;
      end
    end
  end

  // result and request payload
  always_ff @(posedge clk) begin
    if (reply_hit) begin
      dst <= data_in;
    end else if (finish && !is_thread_cmd) begin
      dst <= '0;
    end
    if (send_req) begin
      msg_r  <= req_code;
      addr_r <= req_addr;
      data_r <= req_data;
    end
  end

  // bus quiet outside the pulse cycle
  assign cpu_msg_out = cpu_msg_pulse ? msg_r : msg_none;
  assign addr_out    = cpu_msg_pulse ? addr_r : '0;
  assign data_out    = cpu_msg_pulse ? data_r : '0;

endmodule

// ==== design/thread_dispatcher.sv ====
`timescale 1ns/100ps

module thread_dispatcher (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cpu_msg_pkg::cpu_msg_w-1:0]   cpu_msg_out,
  input  logic                                cpu_msg_pulse,
  input  logic [cpu_core_pkg::addr_w-1:0]     addr_out,
  input  logic [cpu_core_pkg::data_w-1:0]     data_out,
  output logic [cpu_msg_pkg::cpu_msg_w-1:0]   cpu_msg_in,
  output logic [cpu_core_pkg::data_w-1:0]     data_in,
  output logic                                disp_online,
  output logic [cpu_msg_pkg::thread_id_w:0]   live_threads,
  output logic [cpu_core_pkg::data_w-1:0]     exit_value
);
  import cpu_core_pkg::*;
  import cpu_msg_pkg::*;

  // thread table, address is the key
  logic [num_threads-1:0] tbl_valid;
  logic [addr_w-1:0]      tbl_addr [num_threads];
  logic [data_w-1:0]      tbl_arg  [num_threads];

  // request delay line
  // several requests may be in flight
  logic [reply_delay-1:0] dl_valid;
  logic [cpu_msg_w-1:0]   dl_msg  [reply_delay];
  logic [addr_w-1:0]      dl_addr [reply_delay];
  logic [data_w-1:0]      dl_data [reply_delay];

  // table clear walk after reset
  logic [thread_id_w-1:0] init_idx;

  // request leaving the delay line
  logic                 is_fork;
  logic                 is_stop;
  logic [addr_w-1:0]    rq_addr;
  logic [data_w-1:0]    rq_data;

  // table search results
  logic                   free_found;
  logic [thread_id_w-1:0] free_idx;
  logic                   match_found;
  logic [thread_id_w-1:0] match_idx;

  assign is_fork = dl_valid[reply_delay-1] && (dl_msg[reply_delay-1] == msg_fork_thrd);
  assign is_stop = dl_valid[reply_delay-1] && (dl_msg[reply_delay-1] == msg_stop_thrd);
  assign rq_addr = dl_addr[reply_delay-1];
  assign rq_data = dl_data[reply_delay-1];

  // lowest free slot and lowest matching slot
  // scan from the top so the lowest index wins
  always_comb begin
    free_found  = 1'b0;
    free_idx    = '0;
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = num_threads - 1; i >= 0; i--) begin
      if (!tbl_valid[i]) begin
        free_found = 1'b1;
        free_idx   = thread_id_w'(i);
      end
      if (tbl_valid[i] && (tbl_addr[i] == rq_addr)) begin
        match_found = 1'b1;
        match_idx   = thread_id_w'(i);
      end
    end
  end

  // reply comes straight out of the last stage
  always_comb begin
    cpu_msg_in = msg_none;
    data_in    = '0;
    if (is_fork) begin
      cpu_msg_in = msg_fork_done;
      data_in    = free_found ? data_w'(free_idx) : result_none;
    end else if (is_stop) begin
      cpu_msg_in = msg_stop_done;
      data_in    = match_found ? tbl_arg[match_idx] : result_none;
    end
  end

  // live thread count
  always_comb begin
    live_threads = '0;
    for (int i = 0; i < num_threads; i++) begin
      live_threads = live_threads + {{thread_id_w{1'b0}}, tbl_valid[i]};
    end
  end

  // valid bits, init walk and exit value
  always_ff @(posedge clk) begin
    if (rst) begin
      dl_valid    <= '0;
      tbl_valid   <= '0;
      init_idx    <= '0;
      disp_online <= 1'b0;
      exit_value  <= '0;
    end else begin
      dl_valid <= {dl_valid[reply_delay-2:0], cpu_msg_pulse};
      if (!disp_online) begin
        // one entry per cycle, online after the last
        tbl_valid[init_idx] <= 1'b0;
        init_idx            <= init_idx + 1'b1;
        if (init_idx == thread_id_w'(num_threads - 1)) begin
          disp_online <= 1'b1;
        end
      end else if (is_fork && free_found) begin
        tbl_valid[free_idx] <= 1'b1;
      end else if (is_stop && match_found) begin
        tbl_valid[match_idx] <= 1'b0;
        exit_value           <= rq_data;
      end
    end
  end

  // delay line payload and table contents
  always_ff @(posedge clk) begin
    dl_msg[0]  <= cpu_msg_out;
    dl_addr[0] <= addr_out;
    dl_data[0] <= data_out;
    for (int i = 1; i < reply_delay; i++) begin
      dl_msg[i]  <= dl_msg[i-1];
      dl_addr[i] <= dl_addr[i-1];
      dl_data[i] <= dl_data[i-1];
    end
    if (!disp_online) begin
      tbl_addr[init_idx] <= '0;
      tbl_arg[init_idx]  <= '0;
    end else if (is_fork && free_found) begin
      tbl_addr[free_idx] <= rq_addr;
      tbl_arg[free_idx]  <= rq_data;
    end
  end

endmodule

// ==== design/thread_unit_top.sv ====
`timescale 1ns/100ps

module thread_unit_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cmd_valid,
  input  logic [cpu_core_pkg::cmd_w-1:0]    command,
  input  logic [cpu_core_pkg::data_w-1:0]   src0,
  input  logic [cpu_core_pkg::data_w-1:0]   src1,
  input  logic [cpu_core_pkg::addr_w-1:0]   base_addr_data,
  input  logic                              clk_oe,
  output logic                              busy,
  output logic                              done,
  output logic [cpu_core_pkg::data_w-1:0]   dst,
  output logic [cpu_core_pkg::data_w-1:0]   exit_value,
  output logic                              disp_online,
  output logic [cpu_msg_pkg::thread_id_w:0] live_threads
);
  import cpu_core_pkg::*;
  import cpu_msg_pkg::*;

  // sequencer to controller
  logic [state_w-1:0]    state;
  logic [cmd_code_w-1:0] cmd_code;
  logic [data_w-1:0]     op0;
  logic [data_w-1:0]     op1;
  logic                  next_state;

  // controller and dispatcher message bus
  logic [cpu_msg_w-1:0]  cpu_msg_out;
  logic                  cpu_msg_pulse;
  logic [addr_w-1:0]     addr_out;
  logic [data_w-1:0]     data_out;
  logic [cpu_msg_w-1:0]  cpu_msg_in;
  logic [data_w-1:0]     data_in;

  cmd_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .command    (command),
    .src0       (src0),
    .src1       (src1),
    .next_state (next_state),
    .state      (state),
    .cmd_code   (cmd_code),
    .op0        (op0),
    .op1        (op1),
    .busy       (busy),
    .done       (done)
  );

  thread_ctlr u_ctlr (
    .clk            (clk),
    .rst            (rst),
    .clk_oe         (clk_oe),
    .state          (state),
    .cmd_code       (cmd_code),
    .src0           (op0),
    .src1           (op1),
    .base_addr_data (base_addr_data),
    .disp_online    (disp_online),
    .cpu_msg_in     (cpu_msg_in),
    .data_in        (data_in),
    .cpu_msg_out    (cpu_msg_out),
    .cpu_msg_pulse  (cpu_msg_pulse),
    .addr_out       (addr_out),
    .data_out       (data_out),
    .dst            (dst),
    .next_state     (next_state)
  );

  thread_dispatcher u_disp (
    .clk           (clk),
    .rst           (rst),
    .cpu_msg_out   (cpu_msg_out),
    .cpu_msg_pulse (cpu_msg_pulse),
    .addr_out      (addr_out),
    .data_out      (data_out),
    .cpu_msg_in    (cpu_msg_in),
    .data_in       (data_in),
    .disp_online   (disp_online),
    .live_threads  (live_threads),
    .exit_value    (exit_value)
  );

endmodule

// ==== sim/thread_unit_assertions.sv ====
`timescale 1ns/100ps

module thread_unit_assertions (
  input logic                            clk,
  input logic                            rst,
  input logic                            clk_oe,
  input logic                            cpu_msg_pulse,
  input logic [cpu_core_pkg::addr_w-1:0] addr_out,
  input logic [cpu_core_pkg::data_w-1:0] data_out,
  input logic                            next_state
);

  // failures seen so far, read by the testbench
  int fail_count = 0;

  // payload only in the pulse cycle
  quiet_bus: assert property (@(posedge clk) disable iff (rst)
    !cpu_msg_pulse |-> (addr_out == '0) && (data_out == '0))
    else begin
      fail_count++;
      $error("addr_out or data_out nonzero outside the pulse cycle");
    end

  // one request per pulse
  single_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_msg_pulse |=> !cpu_msg_pulse)
    else begin
      fail_count++;
      $error("cpu_msg_pulse high for two cycles");
    end

  // no pipeline step in a halted cycle
  halt_holds: assert property (@(posedge clk) disable iff (rst)
    !clk_oe |-> !next_state)
    else begin
      fail_count++;
      $error("next_state high in a cycle with clk_oe low");
    end

endmodule

// ==== sim/thread_unit_checker.sv ====
`timescale 1ns/100ps

module thread_unit_checker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cmd_valid,
  input  logic                              busy,
  input  logic                              done,
  input  logic [cpu_core_pkg::data_w-1:0]   dst,
  input  logic [cpu_core_pkg::data_w-1:0]   exit_value,
  input  logic                              disp_online,
  input  logic [cpu_msg_pkg::thread_id_w:0] live_threads,
  input  logic [cpu_core_pkg::data_w-1:0]   exp_dst,
  input  logic [cpu_core_pkg::data_w-1:0]   exp_exit,
  input  logic [cpu_msg_pkg::thread_id_w:0] exp_live,
  output int                                value_errors,
  output int                                protocol_errors
);
  import cpu_msg_pkg::*;

  // cycles allowed from strobe to done
  localparam int done_limit = 40;

  // cycles from reset release to disp_online
  int   online_wait;
  logic online_seen;
  // accepted command waiting for done
  logic pending;
  int   pending_age;

  always @(posedge clk) begin
    if (rst) begin
      online_wait     <= 0;
      online_seen     <= 1'b0;
      pending         <= 1'b0;
      pending_age     <= 0;
      value_errors    = 0;
      protocol_errors = 0;
    end else begin
      // table clear window
      if (!online_seen) begin
        if (busy || done) begin
          $display("error: busy or done high before the dispatcher came online");
          protocol_errors++;
        end
        if (disp_online) begin
          online_seen <= 1'b1;
          if (online_wait != num_threads) begin
            $display("[FAIL] disp_online delay: got %h expected %h", online_wait, num_threads);
            value_errors++;
          end
          if (live_threads !== '0) begin
            $display("[FAIL] live_threads: got %h expected %h", live_threads, 0);
            value_errors++;
          end
        end else begin
          online_wait <= online_wait + 1;
        end
      end
      // busy covers the whole command
      if (pending && !busy) begin
        $display("error: busy low while a command was still waiting for done");
        protocol_errors++;
      end
      if (done) begin
        pending <= 1'b0;
        if (!pending) begin
          $display("error: done pulse at %0t with no accepted command", $time);
          protocol_errors++;
        end else begin
          if (dst !== exp_dst) begin
            $display("[FAIL] dst: got %h expected %h", dst, exp_dst);
            value_errors++;
          end
          if (exit_value !== exp_exit) begin
            $display("[FAIL] exit_value: got %h expected %h", exit_value, exp_exit);
            value_errors++;
          end
          if (live_threads !== exp_live) begin
            $display("[FAIL] live_threads: got %h expected %h", live_threads, exp_live);
            value_errors++;
          end
        end
      end else if (cmd_valid && !busy) begin
        pending     <= 1'b1;
        pending_age <= 0;
      end else if (pending) begin
        if (pending_age >= done_limit - 1) begin
          $display("error: no done within %0d cycles of a command strobe", done_limit);
          protocol_errors++;
          pending <= 1'b0;
        end else begin
          pending_age <= pending_age + 1;
        end
      end
    end
  end

endmodule

// ==== sim/thread_unit_tb.sv ====
`timescale 1ns/100ps

module thread_unit_tb;
  import cpu_core_pkg::*;
  import cpu_msg_pkg::*;

  localparam int          clk_period = 4;
  localparam int          num_cmds   = 21;
  // a little beyond the checker's own done limit
  localparam int          wait_limit = 45;
  localparam logic [31:0] seed       = 32'ha2519acf;

  logic                 clk;
  logic                 rst;
  logic                 cmd_valid;
  logic [cmd_w-1:0]     command;
  logic [data_w-1:0]    src0;
  logic [data_w-1:0]    src1;
  logic [addr_w-1:0]    base_addr_data;
  logic                 clk_oe;
  logic                 busy;
  logic                 done;
  logic [data_w-1:0]    dst;
  logic [data_w-1:0]    exit_value;
  logic                 disp_online;
  logic [thread_id_w:0] live_threads;

  // expected values, handed to the checker
  logic [data_w-1:0]    exp_dst;
  logic [data_w-1:0]    exp_exit;
  logic [thread_id_w:0] exp_live;
  int                   value_errors;
  int                   protocol_errors;
  int                   assert_errors;

  // model thread table
  logic                 m_valid [num_threads];
  logic [addr_w-1:0]    m_addr  [num_threads];
  logic [data_w-1:0]    m_arg   [num_threads];

  logic [addr_w-1:0]    base;
  int                   wait_n;
  int                   k;

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  thread_unit_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .cmd_valid      (cmd_valid),
    .command        (command),
    .src0           (src0),
    .src1           (src1),
    .base_addr_data (base_addr_data),
    .clk_oe         (clk_oe),
    .busy           (busy),
    .done           (done),
    .dst            (dst),
    .exit_value     (exit_value),
    .disp_online    (disp_online),
    .live_threads   (live_threads)
  );

  thread_unit_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .cmd_valid       (cmd_valid),
    .busy            (busy),
    .done            (done),
    .dst             (dst),
    .exit_value      (exit_value),
    .disp_online     (disp_online),
    .live_threads    (live_threads),
    .exp_dst         (exp_dst),
    .exp_exit        (exp_exit),
    .exp_live        (exp_live),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors)
  );

  // handshake properties on the controller
  bind thread_ctlr thread_unit_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .clk_oe        (clk_oe),
    .cpu_msg_pulse (cpu_msg_pulse),
    .addr_out      (addr_out),
    .data_out      (data_out),
    .next_state    (next_state)
  );

  assign assert_errors = u_dut.u_ctlr.u_assertions.fail_count;

  // expected dst, exit value and live count for one command
  function automatic void model_command(
    input logic [cmd_code_w-1:0] code,
    input logic [data_w-1:0]     s0,
    input logic [data_w-1:0]     s1,
    input logic [addr_w-1:0]     base_in
  );
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] arg;
    int                slot;
    addr    = s0 + base_in;
    arg     = (s1 != '0) ? s1 + base_in : s0 + base_in;
    slot    = -1;
    exp_dst = '0;
    if (code == cmd_fork) begin
      // first free entry from the bottom
      for (int i = 0; i < num_threads; i++) begin
        if (slot < 0 && !m_valid[i]) begin
          slot = i;
        end
      end
      if (slot < 0) begin
        exp_dst = result_none;
      end else begin
        m_valid[slot] = 1'b1;
        m_addr[slot]  = addr;
        m_arg[slot]   = arg;
        exp_dst       = data_w'(slot);
      end
    end else if (code == cmd_stop) begin
      // first live entry with the same address
      for (int i = 0; i < num_threads; i++) begin
        if (slot < 0 && m_valid[i] && m_addr[i] == addr) begin
          slot = i;
        end
      end
      if (slot < 0) begin
        exp_dst = result_none;
      end else begin
        m_valid[slot] = 1'b0;
        exp_dst       = m_arg[slot];
        exp_exit      = arg;
      end
    end
    exp_live = '0;
    for (int i = 0; i < num_threads; i++) begin
      exp_live = exp_live + m_valid[i];
    end
  endfunction

  // one command from strobe to done, optional clk_oe stalls
  task automatic run_command(
    input logic [cmd_code_w-1:0] code,
    input logic [data_w-1:0]     s0,
    input logic [data_w-1:0]     s1,
    input logic [addr_w-1:0]     base_in,
    input logic                  stall
  );
    logic [cmd_w-1:0] word;
    int               cycles;
    int               lo_start;
    int               lo_len;
    logic             seen;
    word = $urandom;
    word[cmd_code_lsb +: cmd_code_w] = code;
    lo_start = $urandom_range(1, 5);
    lo_len   = $urandom_range(1, 4);
    model_command(code, s0, s1, base_in);
    command        = word;
    src0           = s0;
    src1           = s1;
    base_addr_data = base_in;
    cmd_valid      = 1'b1;
    @(posedge clk);
    #1;
    // repeat strobe while busy, should be dropped
    cmd_valid = stall;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(posedge clk);
      #1;
      cycles++;
      seen      = done;
      cmd_valid = 1'b0;
      if (stall) begin
        clk_oe = !(cycles >= lo_start && cycles < lo_start + lo_len);
      end
    end
    clk_oe = 1'b1;
    // done cycle is still busy, back to idle one edge later
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(seed));
    rst            = 1'b1;
    cmd_valid      = 1'b0;
    command        = '0;
    src0           = '0;
    src1           = '0;
    base_addr_data = '0;
    clk_oe         = 1'b1;
    exp_dst        = '0;
    exp_exit       = '0;
    exp_live       = '0;
    for (int i = 0; i < num_threads; i++) begin
      m_valid[i] = 1'b0;
      m_addr[i]  = '0;
      m_arg[i]   = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // table clear walk
    wait_n = 0;
    while (!disp_online && wait_n < 4 * num_threads) begin
      @(posedge clk);
      #1;
      wait_n++;
    end
    // fill every slot, then one fork too many
    for (int i = 0; i <= num_threads; i++) begin
      run_command(cmd_fork, $urandom, (i == 3) ? 32'd0 : $urandom, $urandom, 1'b0);
    end
    // stop a live thread, then refill its slot
    k    = $urandom_range(0, num_threads - 1);
    base = $urandom;
    run_command(cmd_stop, m_addr[k] - base, $urandom, base, 1'b0);
    run_command(cmd_fork, $urandom, $urandom, $urandom, 1'b0);
    // stop with an unknown address
    run_command(cmd_stop, $urandom, $urandom, $urandom, 1'b0);
    // codes with no thread meaning
    run_command(4'h0, $urandom, $urandom, $urandom, 1'b0);
    run_command(4'h3, $urandom, $urandom, $urandom, 1'b0);
    run_command(4'hf, $urandom, $urandom, $urandom, 1'b0);
    // stop and fork again with clk_oe stalls
    repeat (3) begin
      k    = $urandom_range(0, num_threads - 1);
      base = $urandom;
      run_command(cmd_stop, m_addr[k] - base, $urandom, base, 1'b1);
      run_command(cmd_fork, $urandom, $urandom, $urandom, 1'b1);
    end
    repeat (3) @(posedge clk);
    $display("errors: %0d value, %0d protocol, %0d assertion",
             value_errors, protocol_errors, assert_errors);
    if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // 60 cycles per command on top of reset and table clear
  initial begin
    #((num_cmds * 60 + 5 + num_threads) * clk_period);
    $display("error: watchdog expired before the command sequence finished");
    $display("Some tests failed");
    $finish;
  end

endmodule
